// ==== mc_noc_pkg.sv ====
package mc_noc_pkg;

  // grid of endpoints, row 0 is north and the last row is south.
  localparam int num_cols = 2;
  localparam int num_rows = 4;
  localparam int num_ports = num_rows * num_cols;

  // every row except the tile row leaves the crossbar as plain ports.
  localparam int num_edge_ports = num_ports - num_cols;

  localparam int north_row = 0;
  localparam int io_row = 1;
  localparam int tile_row = 2;
  localparam int south_row = 3;

  localparam int reset_depth = 4; // flops in the reset chain.

  typedef logic [$clog2(num_cols)-1:0] x_cord_t;
  typedef logic [$clog2(num_rows)-1:0] y_cord_t;

  // crossbar port number, row * num_cols + column.
  typedef logic [$clog2(num_ports)-1:0] port_idx_t;

endpackage

// ==== mc_packet_pkg.sv ====
package mc_packet_pkg;

  import mc_noc_pkg::*;

  localparam int tile_mem_words = 256;
  localparam int tile_credits = 2;

  // matches tile_credits, so a tile holding a credit always finds room.
  localparam int fifo_depth = 2;

  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_load  = 2'd1,
    op_resp  = 2'd2
  } mc_op_e;

  typedef logic [$clog2(tile_mem_words)-1:0] addr_t;
  typedef logic [31:0] data_t;

  typedef logic [$clog2(tile_credits+1)-1:0] credit_t;
  typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
  typedef logic [$clog2(fifo_depth+1)-1:0] fifo_cnt_t;

  // single flit, 48 bits in all.
  typedef struct packed {
    mc_op_e  op;
    x_cord_t dest_x;
    y_cord_t dest_y;
    x_cord_t src_x;
    y_cord_t src_y;
    addr_t   addr;
    data_t   data;
  } mc_packet_s;

endpackage

// ==== mc_link_if.sv ====
`timescale 1ns/1ns

interface mc_link_if
  import mc_packet_pkg::*;
();

  logic       v;
  logic       ready;
  logic       credit;
  mc_packet_s pkt;

  // the side that puts packets onto the link.
  modport endpoint (
    output v,
    output pkt,
    input  ready,
    input  credit
  );

  // the side that takes packets off the link and hands back credits.
  modport network (
    input  v,
    input  pkt,
    output ready,
    output credit
  );

endinterface

// ==== mc_reset_stager.sv ====
`timescale 1ns/1ns

module mc_reset_stager
  import mc_noc_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  output logic net_rst_o,
  output logic tile_rst_o
);

  logic [reset_depth-1:0] rst_r;

  // zeros shift in after the external reset lifts.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_r <= '1;
    end else begin
      rst_r <= {rst_r[reset_depth-2:0], 1'b0};
    end
  end

  assign net_rst_o  = rst_r[reset_depth-2];
  assign tile_rst_o = rst_r[reset_depth-1]; // one cycle behind the network.

endmodule

// ==== mc_rr_arbiter.sv ====
`timescale 1ns/1ns

module mc_rr_arbiter
  import mc_noc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [num_ports-1:0] req_i,
  input  logic                 advance_i,
  output logic [num_ports-1:0] grant_o,
  output logic                 grant_v_o
);

  port_idx_t last_r;
  port_idx_t grant_idx;
  port_idx_t cand;

  // search starts just after the last winner and wraps around to it.
  always_comb begin
    grant_o   = '0;
    grant_v_o = 1'b0;
    grant_idx = last_r;
    cand      = last_r;
    for (int k = 1; k <= num_ports; k++) begin
      cand = last_r + port_idx_t'(k);
      if (!grant_v_o && req_i[cand]) begin
        grant_o[cand] = 1'b1;
        grant_v_o     = 1'b1;
        grant_idx     = cand;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_r <= port_idx_t'(num_ports - 1); // so port 0 wins first.
    end else if (advance_i && grant_v_o) begin
      last_r <= grant_idx;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) grant_v_o |-> $onehot(grant_o))
    else $error("mc_rr_arbiter: grant is not one-hot");

endmodule

// ==== mc_link_fifo.sv ====
`timescale 1ns/1ns

module mc_link_fifo
  import mc_packet_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       v_i,
  input  mc_packet_s pkt_i,
  input  logic       deq_i,
  output logic       ready_o,
  output logic       v_o,
  output mc_packet_s pkt_o,
  output logic       credit_o
);

  mc_packet_s mem_r [fifo_depth];
  fifo_ptr_t  wr_ptr_r;
  fifo_ptr_t  rd_ptr_r;
  fifo_cnt_t  count_r;
  logic       up_r;
  logic       credit_r;
  logic       enq;

  // up_r keeps ready low until the first cycle out of reset.
  assign ready_o  = up_r && (count_r != fifo_cnt_t'(fifo_depth));
  assign v_o      = (count_r != '0);
  assign pkt_o    = mem_r[rd_ptr_r];
  assign credit_o = credit_r;
  assign enq      = v_i && ready_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      up_r     <= 1'b0;
      credit_r <= 1'b0;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      up_r     <= 1'b1;
      credit_r <= deq_i; // one pulse per packet that leaves.
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq_i) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({enq, deq_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= pkt_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) deq_i |-> v_o)
    else $error("mc_link_fifo: dequeue from an empty fifo");

  // an enqueue into a full fifo would move the write pointer past the count.
  assert property (@(posedge clk_i) disable iff (rst_i)
                   wr_ptr_r == fifo_ptr_t'(rd_ptr_r + count_r))
    else $error("mc_link_fifo: write pointer disagrees with the count");

endmodule

// ==== mc_crossbar.sv ====
`timescale 1ns/1ns

module mc_crossbar
  import mc_noc_pkg::*;
  import mc_packet_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic       [num_edge_ports-1:0]   edge_v_i,
  input  mc_packet_s [num_edge_ports-1:0]   edge_pkt_i,
  output logic       [num_edge_ports-1:0]   edge_ready_o,
  output logic       [num_edge_ports-1:0]   edge_v_o,
  output mc_packet_s [num_edge_ports-1:0]   edge_pkt_o,
  input  logic       [num_edge_ports-1:0]   edge_ready_i,
  mc_link_if.network                        tile_in  [num_cols],
  mc_link_if.endpoint                       tile_out [num_cols]
);

  logic [num_ports-1:0] in_v;
  logic [num_ports-1:0] fifo_rdy;
  logic [num_ports-1:0] fifo_v;
  logic [num_ports-1:0] deq;
  logic [num_ports-1:0] credit;
  logic [num_ports-1:0] out_v_r;
  logic [num_ports-1:0] out_ready;
  logic [num_ports-1:0] grant_v;
  logic [num_ports-1:0] load;
  logic [num_ports-1:0] req   [num_ports]; // req[output][input].
  logic [num_ports-1:0] grant [num_ports];

  mc_packet_s in_pkt    [num_ports];
  mc_packet_s fifo_pkt  [num_ports];
  mc_packet_s sel_pkt   [num_ports];
  mc_packet_s out_pkt_r [num_ports];
  port_idx_t  dest_idx  [num_ports];

  for (genvar r = 0; r < num_rows; r++) begin : g_row
    for (genvar c = 0; c < num_cols; c++) begin : g_col
      localparam int p = r * num_cols + c;
      if (r == tile_row) begin : g_tile
        assign in_v[p]            = tile_in[c].v;
        assign in_pkt[p]          = tile_in[c].pkt;
        assign tile_in[c].ready   = 1'b1; // the tile's credit already reserved a slot.
        assign tile_in[c].credit  = credit[p];
        assign tile_out[c].v      = out_v_r[p];
        assign tile_out[c].pkt    = out_pkt_r[p];
        assign out_ready[p]       = tile_out[c].ready;

        // a tile that respects its credits never finds its fifo full.
        assert property (@(posedge clk_i) disable iff (rst_i) tile_in[c].v |-> fifo_rdy[p])
          else $error("mc_crossbar: tile %0d sent without a free fifo slot", c);
      end else begin : g_edge
        // north and io keep their port number, south skips the tile row.
        localparam int e = (r == south_row) ? p - num_cols : p;
        assign in_v[p]         = edge_v_i[e];
        assign in_pkt[p]       = edge_pkt_i[e];
        assign edge_ready_o[e] = fifo_rdy[p];
        assign edge_v_o[e]     = out_v_r[p];
        assign edge_pkt_o[e]   = out_pkt_r[p];
        assign out_ready[p]    = edge_ready_i[e];
      end
    end
  end

  // index i is an input for the fifo and an output for the arbiter.
  for (genvar i = 0; i < num_ports; i++) begin : g_port
    mc_link_fifo fifo_inst (
      .clk_i,
      .rst_i,
      .v_i      (in_v[i]),
      .pkt_i    (in_pkt[i]),
      .deq_i    (deq[i]),
      .ready_o  (fifo_rdy[i]),
      .v_o      (fifo_v[i]),
      .pkt_o    (fifo_pkt[i]),
      .credit_o (credit[i])
    );

    assign dest_idx[i] = port_idx_t'(int'(fifo_pkt[i].dest_y) * num_cols
                                     + int'(fifo_pkt[i].dest_x));

    mc_rr_arbiter arb_inst (
      .clk_i,
      .rst_i,
      .req_i     (req[i]),
      .advance_i (load[i]),
      .grant_o   (grant[i]),
      .grant_v_o (grant_v[i])
    );

    // the register takes a new packet when empty or draining this cycle.
    assign load[i] = grant_v[i] && (!out_v_r[i] || out_ready[i]);
  end

  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      sel_pkt[o] = '0;
      for (int i = 0; i < num_ports; i++) begin
        req[o][i] = fifo_v[i] && (dest_idx[i] == port_idx_t'(o));
        if (grant[o][i]) begin
          sel_pkt[o] = fifo_pkt[i];
        end
      end
    end
  end

  // a head targets one output only, so at most one load claims it.
  always_comb begin
    deq = '0;
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        if (load[o] && grant[o][i]) begin
          deq[i] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      out_v_r <= '0;
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        if (load[o]) begin
          out_v_r[o] <= 1'b1;
        end else if (out_ready[o]) begin
          out_v_r[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < num_ports; o++) begin
      if (load[o]) begin
        out_pkt_r[o] <= sel_pkt[o];
      end
    end
  end

endmodule

// ==== mc_mem_tile.sv ====
`timescale 1ns/1ns

module mc_mem_tile
  import mc_noc_pkg::*;
  import mc_packet_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  x_cord_t     my_x_i,
  mc_link_if.network  link_in,
  mc_link_if.endpoint link_out
);

  data_t      mem_r [tile_mem_words];
  mc_packet_s req;
  mc_packet_s resp_pkt_r;
  logic       resp_v_r;
  credit_t    credit_r;
  logic       send;
  logic       accept;

  assign req    = link_in.pkt;
  assign send   = resp_v_r && (credit_r != '0);
  assign accept = link_in.v && link_in.ready;

  // a response waiting on credit blocks further requests.
  assign link_in.ready = !resp_v_r || send;

  assign link_out.v   = send;
  assign link_out.pkt = resp_pkt_r;

  always_ff @(posedge clk_i) begin
    if (accept && req.op == op_store) begin
      mem_r[req.addr] <= req.data;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      resp_v_r <= 1'b0;
    end else if (accept && req.op == op_load) begin
      resp_v_r <= 1'b1;
    end else if (send) begin
      resp_v_r <= 1'b0;
    end
  end

  // the answer goes back to whoever asked.
  always_ff @(posedge clk_i) begin
    if (accept && req.op == op_load) begin
      resp_pkt_r.op     <= op_resp;
      resp_pkt_r.dest_x <= req.src_x;
      resp_pkt_r.dest_y <= req.src_y;
      resp_pkt_r.src_x  <= my_x_i;
      resp_pkt_r.src_y  <= y_cord_t'(tile_row);
      resp_pkt_r.addr   <= req.addr;
      resp_pkt_r.data   <= mem_r[req.addr];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      credit_r <= credit_t'(tile_credits);
    end else begin
      case ({send, link_out.credit})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) credit_r <= credit_t'(tile_credits))
    else $error("mc_mem_tile: more credits returned than were spent");

endmodule

// ==== mc_top_crossbar.sv ====
`timescale 1ns/1ns

module mc_top_crossbar
  import mc_noc_pkg::*;
  import mc_packet_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  input  logic       [num_cols-1:0]   north_v_i,
  input  mc_packet_s [num_cols-1:0]   north_pkt_i,
  output logic       [num_cols-1:0]   north_ready_o,
  output logic       [num_cols-1:0]   north_v_o,
  output mc_packet_s [num_cols-1:0]   north_pkt_o,
  input  logic       [num_cols-1:0]   north_ready_i,

  input  logic       [num_cols-1:0]   io_v_i,
  input  mc_packet_s [num_cols-1:0]   io_pkt_i,
  output logic       [num_cols-1:0]   io_ready_o,
  output logic       [num_cols-1:0]   io_v_o,
  output mc_packet_s [num_cols-1:0]   io_pkt_o,
  input  logic       [num_cols-1:0]   io_ready_i,

  input  logic       [num_cols-1:0]   south_v_i,
  input  mc_packet_s [num_cols-1:0]   south_pkt_i,
  output logic       [num_cols-1:0]   south_ready_o,
  output logic       [num_cols-1:0]   south_v_o,
  output mc_packet_s [num_cols-1:0]   south_pkt_o,
  input  logic       [num_cols-1:0]   south_ready_i
);

  logic                            net_rst;
  logic                            tile_rst;
  logic       [num_edge_ports-1:0] edge_v_i;
  mc_packet_s [num_edge_ports-1:0] edge_pkt_i;
  logic       [num_edge_ports-1:0] edge_ready_o;
  logic       [num_edge_ports-1:0] edge_v_o;
  mc_packet_s [num_edge_ports-1:0] edge_pkt_o;
  logic       [num_edge_ports-1:0] edge_ready_i;

  mc_link_if tile_to_net [num_cols] ();
  mc_link_if net_to_tile [num_cols] ();

  // edge order is north, io, south, column 0 first within each.
  assign edge_v_i     = {south_v_i, io_v_i, north_v_i};
  assign edge_pkt_i   = {south_pkt_i, io_pkt_i, north_pkt_i};
  assign edge_ready_i = {south_ready_i, io_ready_i, north_ready_i};

  assign {south_ready_o, io_ready_o, north_ready_o} = edge_ready_o;
  assign {south_v_o, io_v_o, north_v_o}             = edge_v_o;
  assign {south_pkt_o, io_pkt_o, north_pkt_o}       = edge_pkt_o;

  mc_reset_stager reset_stager_inst (
    .clk_i,
    .arst_n_i,
    .net_rst_o  (net_rst),
    .tile_rst_o (tile_rst)
  );

  mc_crossbar crossbar_inst (
    .clk_i,
    .rst_i        (net_rst),
    .edge_v_i     (edge_v_i),
    .edge_pkt_i   (edge_pkt_i),
    .edge_ready_o (edge_ready_o),
    .edge_v_o     (edge_v_o),
    .edge_pkt_o   (edge_pkt_o),
    .edge_ready_i (edge_ready_i),
    .tile_in      (tile_to_net),
    .tile_out     (net_to_tile)
  );

  for (genvar c = 0; c < num_cols; c++) begin : g_tile
    mc_mem_tile tile_inst (
      .clk_i,
      .rst_i    (tile_rst),
      .my_x_i   (x_cord_t'(c)),
      .link_in  (net_to_tile[c]),
      .link_out (tile_to_net[c])
    );
  end

endmodule

// ==== mc_checker.sv ====
`timescale 1ns/1ns

module mc_checker
  import mc_noc_pkg::*;
  import mc_packet_pkg::*;
(
  input logic                              clk_i,
  input logic                              arst_n_i,
  input logic       [num_edge_ports-1:0]   v_in_i,
  input mc_packet_s [num_edge_ports-1:0]   pkt_in_i,
  input logic       [num_edge_ports-1:0]   ready_in_i,
  input logic       [num_edge_ports-1:0]   v_out_i,
  input mc_packet_s [num_edge_ports-1:0]   pkt_out_i,
  input logic       [num_edge_ports-1:0]   ready_out_i
);

  data_t                     mem_model [num_cols][tile_mem_words];
  mc_packet_s                exp_q     [num_edge_ports][$]; // per edge endpoint.
  mc_packet_s                held_pkt  [num_edge_ports];
  logic [num_edge_ports-1:0] held = '0;

  string test_name      = "reset";
  int    mismatch_count = 0;
  int    error_count    = 0;
  int    accepted       = 0;
  int    stalls         = 0;

  task automatic start_test(string name);
    test_name = name;
  endtask

  task automatic clear_stalls();
    stalls = 0;
  endtask

  task automatic require_stall();
    if (stalls == 0) begin
      error_count++;
      $display("test %s never saw an input ready drop under back-pressure", test_name);
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int e = 0; e < num_edge_ports; e++) begin
      n += exp_q[e].size();
    end
    return n;
  endfunction

  task automatic report_leftovers();
    for (int e = 0; e < num_edge_ports; e++) begin
      if (exp_q[e].size() != 0) begin
        error_count += exp_q[e].size();
        $display("edge port %0d still waits for %0d packet(s) that never came out",
                 e, exp_q[e].size());
      end
    end
  endtask

  // edge ports count north, io, south and skip the tile row.
  function automatic int edge_of(x_cord_t x, y_cord_t y);
    if (int'(y) == tile_row) begin
      return -1;
    end
    if (int'(y) == south_row) begin
      return (int'(y) - 1) * num_cols + int'(x);
    end
    return int'(y) * num_cols + int'(x);
  endfunction

  task automatic accept_packet(mc_packet_s p);
    mc_packet_s r;
    accepted++;
    if (p.dest_y != y_cord_t'(tile_row)) begin
      exp_q[edge_of(p.dest_x, p.dest_y)].push_back(p); // edge traffic passes unchanged.
    end else if (p.op == op_store) begin
      mem_model[p.dest_x][p.addr] = p.data;
    end else if (p.op == op_load) begin
      r.op     = op_resp;
      r.dest_x = p.src_x;
      r.dest_y = p.src_y;
      r.src_x  = p.dest_x;
      r.src_y  = y_cord_t'(tile_row);
      r.addr   = p.addr;
      r.data   = mem_model[p.dest_x][p.addr];
      exp_q[edge_of(r.dest_x, r.dest_y)].push_back(r);
    end
  endtask

  task automatic match_packet(int e, mc_packet_s p);
    int hit;
    hit = -1;
    for (int k = 0; k < exp_q[e].size(); k++) begin
      if (hit < 0 && exp_q[e][k] === p) begin
        hit = k;
      end
    end
    if (hit >= 0) begin
      exp_q[e].delete(hit);
    end else if (exp_q[e].size() == 0) begin
      mismatch_count++;
      $display("MISMATCH test %s port %0d expected nothing actual %h", test_name, e, p);
    end else begin
      mismatch_count++;
      $display("MISMATCH test %s port %0d expected %h actual %h",
               test_name, e, exp_q[e][0], p);
    end
  endtask

  // the negative edge sees the values that the next rising edge acts on.
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      if (v_out_i != '0 || ready_in_i != '0) begin
        error_count++;
        $display("edge valid or ready outputs are high during reset");
      end
    end else begin
      if (accepted == 0 && v_out_i != '0) begin
        error_count++;
        $display("an output went valid before any packet was sent");
      end
      for (int e = 0; e < num_edge_ports; e++) begin
        if (held[e] && !(v_out_i[e] && pkt_out_i[e] === held_pkt[e])) begin
          error_count++;
          $display("port %0d changed a stalled packet before its transfer in test %s",
                   e, test_name);
        end
        held[e]     = v_out_i[e] && !ready_out_i[e];
        held_pkt[e] = pkt_out_i[e];
        if (v_in_i[e] && !ready_in_i[e]) begin
          stalls++;
        end
        if (v_in_i[e] && ready_in_i[e]) begin
          accept_packet(pkt_in_i[e]);
        end
        if (v_out_i[e] && ready_out_i[e]) begin
          match_packet(e, pkt_out_i[e]);
        end
      end
    end
  end

endmodule

// ==== mc_top_crossbar_tb.sv ====
`timescale 1ns/1ns

module mc_top_crossbar_tb
  import mc_noc_pkg::*;
  import mc_packet_pkg::*;
();

  localparam int drive_delay   = 5;
  localparam int reset_cycles  = 8;
  localparam int send_timeout  = 200;
  localparam int drain_timeout = 400;
  localparam int ready_timeout = 20;
  localparam int settle_cycles = 6; // lets a store reach its tile before the next batch.
  localparam int random_count  = 20;
  localparam int random_addrs  = 16;

  // edge indices as the DUT packs them, and crossbar port numbers.
  localparam int e_north1 = 1;
  localparam int e_io0    = 2;
  localparam int e_io1    = 3;
  localparam int e_south0 = 4;
  localparam int e_south1 = 5;
  localparam int p_north0 = 0;
  localparam int p_north1 = 1;
  localparam int p_io0    = 2;
  localparam int p_io1    = 3;
  localparam int p_tile0  = 4;
  localparam int p_tile1  = 5;
  localparam int p_south0 = 6;
  localparam int p_south1 = 7;

  logic                            clk_i = 1'b0;
  logic                            arst_n_i;
  logic       [num_edge_ports-1:0] drv_v;
  mc_packet_s [num_edge_ports-1:0] drv_pkt;
  logic       [num_edge_ports-1:0] drv_rdy;
  logic       [num_edge_ports-1:0] dut_ready;
  logic       [num_edge_ports-1:0] dut_v;
  mc_packet_s [num_edge_ports-1:0] dut_pkt;

  // stimulus table, one row per packet; rows sharing a batch go out together.
  string                     t_name  [$];
  int                        t_batch [$];
  int                        t_src   [$];
  mc_packet_s                t_pkt   [$];
  logic [num_edge_ports-1:0] t_rdy   [$];
  int                        t_hold  [$];

  int seed     = 32'hfb297d12;
  int timeouts = 0;
  bit aborted  = 1'b0;

  always #50 clk_i = ~clk_i;

  mc_top_crossbar mc_top_crossbar_inst (
    .clk_i,
    .arst_n_i,
    .north_v_i     (drv_v[1:0]),
    .north_pkt_i   (drv_pkt[1:0]),
    .north_ready_o (dut_ready[1:0]),
    .north_v_o     (dut_v[1:0]),
    .north_pkt_o   (dut_pkt[1:0]),
    .north_ready_i (drv_rdy[1:0]),
    .io_v_i        (drv_v[3:2]),
    .io_pkt_i      (drv_pkt[3:2]),
    .io_ready_o    (dut_ready[3:2]),
    .io_v_o        (dut_v[3:2]),
    .io_pkt_o      (dut_pkt[3:2]),
    .io_ready_i    (drv_rdy[3:2]),
    .south_v_i     (drv_v[5:4]),
    .south_pkt_i   (drv_pkt[5:4]),
    .south_ready_o (dut_ready[5:4]),
    .south_v_o     (dut_v[5:4]),
    .south_pkt_o   (dut_pkt[5:4]),
    .south_ready_i (drv_rdy[5:4])
  );

  mc_checker checker_inst (
    .clk_i,
    .arst_n_i,
    .v_in_i      (drv_v),
    .pkt_in_i    (drv_pkt),
    .ready_in_i  (dut_ready),
    .v_out_i     (dut_v),
    .pkt_out_i   (dut_pkt),
    .ready_out_i (drv_rdy)
  );

  function automatic int port_of_edge(int e);
    return (e < 2 * num_cols) ? e : e + num_cols; // south sits past the tile row.
  endfunction

  function automatic mc_packet_s make_pkt(mc_op_e op, int src_p, int dest_p, int addr,
                                          data_t data);
    mc_packet_s p;
    p.op     = op;
    p.dest_x = x_cord_t'(dest_p % num_cols);
    p.dest_y = y_cord_t'(dest_p / num_cols);
    p.src_x  = x_cord_t'(src_p % num_cols);
    p.src_y  = y_cord_t'(src_p / num_cols);
    p.addr   = addr_t'(addr);
    p.data   = data;
    return p;
  endfunction

  task automatic add_entry(string name, int batch, int src_e, mc_packet_s pkt,
                           logic [num_edge_ports-1:0] rdy = '1, int hold = 0);
    t_name.push_back(name);
    t_batch.push_back(batch);
    t_src.push_back(src_e);
    t_pkt.push_back(pkt);
    t_rdy.push_back(rdy);
    t_hold.push_back(hold);
  endtask

  task automatic build_table();
    int src_e;
    int x;
    int a;
    bit is_load;
    bit written [num_cols][random_addrs];
    add_entry("route_io0_north1", 0, e_io0,
              make_pkt(op_store, p_io0, p_north1, 16, 32'ha0010001));
    add_entry("route_io1_south0", 1, e_io1,
              make_pkt(op_load, p_io1, p_south0, 17, 32'ha0020002));
    add_entry("route_south1_io0", 2, e_south1,
              make_pkt(op_resp, p_south1, p_io0, 18, 32'ha0030003));
    add_entry("route_io1_north0", 3, e_io1,
              make_pkt(op_store, p_io1, p_north0, 19, 32'ha0040004));
    add_entry("route_south0_io1", 4, e_south0,
              make_pkt(op_store, p_south0, p_io1, 20, 32'ha0050005));
    add_entry("store_tile0", 5, e_io0, make_pkt(op_store, p_io0, p_tile0, 5, 32'h12340000));
    add_entry("store_tile1", 6, e_south0,
              make_pkt(op_store, p_south0, p_tile1, 5, 32'h56780001));
    add_entry("restore_tile0", 7, e_io1, make_pkt(op_store, p_io1, p_tile0, 5, 32'h9abc0002));
    add_entry("load_tile0", 8, e_io1, make_pkt(op_load, p_io1, p_tile0, 5, '0));
    add_entry("load_tile1", 9, e_north1, make_pkt(op_load, p_north1, p_tile1, 5, '0));
    add_entry("contention_north0", 10, e_io0, make_pkt(op_store, p_io0, p_north0, 1, 32'hc0));
    add_entry("contention_north0", 10, e_io1, make_pkt(op_store, p_io1, p_north0, 2, 32'hc1));
    add_entry("contention_north0", 10, e_south0,
              make_pkt(op_store, p_south0, p_north0, 3, 32'hc2));
    // north0 stalls for 30 cycles while edge packets and tile responses pile up.
    // four from io0 overfill its fifo behind the held output register.
    for (int k = 0; k < 4; k++) begin
      add_entry("backpressure_north0", 11, e_io0,
                make_pkt(op_store, p_io0, p_north0, k, 32'hb0 + k), 6'b111110, 30);
    end
    for (int k = 0; k < 2; k++) begin
      add_entry("backpressure_north0", 11, e_io1, make_pkt(op_load, p_north0, p_tile0, 5, '0));
      add_entry("backpressure_north0", 11, e_south1,
                make_pkt(op_load, p_north0, p_tile1, 5, '0));
    end
    for (int k = 0; k < random_count; k++) begin
      src_e   = $unsigned($random(seed)) % num_edge_ports;
      x       = $unsigned($random(seed)) % num_cols;
      a       = $unsigned($random(seed)) % random_addrs;
      is_load = $random(seed) & 1;
      if (!written[x][a]) begin
        is_load = 1'b0; // never load a word that holds no data yet.
      end
      written[x][a] = 1'b1;
      add_entry($sformatf("random_%0d", k), 12 + k, src_e,
                make_pkt(is_load ? op_load : op_store, port_of_edge(src_e), p_tile0 + x, a,
                         $random(seed)));
    end
  endtask

  task automatic give_up(string what);
    $display("timeout while waiting for %s in test %s", what, checker_inst.test_name);
    timeouts++;
    aborted = 1'b1;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!aborted && dut_ready != '1) begin
      @(posedge clk_i);
      #drive_delay;
      cycles++;
      if (cycles > ready_timeout) begin
        give_up("input ready after reset");
      end
    end
  endtask

  task automatic run_batch(int first, int last);
    int                        pend [num_edge_ports][$];
    logic [num_edge_ports-1:0] fired;
    int                        cycles;
    bit                        busy;
    checker_inst.start_test(t_name[first]);
    checker_inst.clear_stalls();
    for (int i = first; i <= last; i++) begin
      pend[t_src[i]].push_back(i);
    end
    drv_rdy = t_rdy[first];
    cycles  = 0;
    busy    = 1'b1;
    while (busy && !aborted) begin
      for (int e = 0; e < num_edge_ports; e++) begin
        drv_v[e] = (pend[e].size() != 0);
        if (pend[e].size() != 0) begin
          drv_pkt[e] = t_pkt[pend[e][0]];
        end
      end
      @(negedge clk_i);
      fired = drv_v & dut_ready; // transfers of the coming rising edge.
      @(posedge clk_i);
      #drive_delay;
      cycles++;
      busy = (cycles < t_hold[first]);
      for (int e = 0; e < num_edge_ports; e++) begin
        if (fired[e]) begin
          void'(pend[e].pop_front());
        end
        if (pend[e].size() != 0) begin
          busy = 1'b1;
        end
      end
      if (cycles >= t_hold[first]) begin
        drv_rdy = '1;
      end
      if (cycles > t_hold[first] + send_timeout) begin
        give_up("input handshakes");
      end
    end
    drv_v  = '0;
    cycles = 0;
    while (!aborted && checker_inst.pending() != 0) begin
      @(posedge clk_i);
      #drive_delay;
      cycles++;
      if (cycles > drain_timeout) begin
        give_up("expected output packets");
      end
    end
    repeat (settle_cycles) @(posedge clk_i);
    #drive_delay;
    if (!aborted && t_hold[first] > 0) begin
      checker_inst.require_stall();
    end
  endtask

  initial begin
    int first;
    int last;
    arst_n_i = 1'b0;
    drv_v    = '0;
    drv_pkt  = '0;
    drv_rdy  = '1;
    build_table();
    repeat (reset_cycles) @(posedge clk_i);
    #drive_delay;
    arst_n_i = 1'b1;
    wait_ready();
    first = 0;
    while (!aborted && first < t_batch.size()) begin
      last = first;
      while (last + 1 < t_batch.size() && t_batch[last + 1] == t_batch[first]) begin
        last++;
      end
      run_batch(first, last);
      first = last + 1;
    end
    if (!aborted) begin
      checker_inst.report_leftovers();
    end
    $display("errors: mismatches %0d, other %0d, timeouts %0d",
             checker_inst.mismatch_count, checker_inst.error_count, timeouts);
    if (checker_inst.mismatch_count == 0 && checker_inst.error_count == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== mc_top_crossbar.f ====
mc_noc_pkg.sv
mc_packet_pkg.sv
mc_link_if.sv
mc_reset_stager.sv
mc_rr_arbiter.sv
mc_link_fifo.sv
mc_crossbar.sv
mc_mem_tile.sv
mc_top_crossbar.sv
mc_checker.sv
mc_top_crossbar_tb.sv

// ==== Makefile ====
TB_TOP = mc_top_crossbar_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TB_TOP) -f mc_top_crossbar.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f mc_top_crossbar.f -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
